// ==== conv_pkg.sv ====
package conv_pkg;

  localparam int data_w    = 32;
  localparam int sample_w  = 8;
  localparam int mag_w     = 8;
  localparam int acc_w     = 32;
  localparam int n_ch      = 4;
  localparam int n_tap     = 3;
  localparam int be_w      = data_w / 8;      // byte enables per word
  localparam int code_w    = 2;               // one weight code
  localparam int ch_code_w = n_tap * code_w;  // codes of one channel
  localparam int ch_sel_w  = $clog2(n_ch);

  // signed 8-bit output range
  localparam int sat_max = 127;
  localparam int sat_min = -128;

  typedef enum logic [1:0] {
    w_zero = 2'd0,
    w_pos  = 2'd1,  // + sample * pos_w
    w_neg1 = 2'd2,  // - sample * neg_w1
    w_neg2 = 2'd3   // - sample * neg_w2
  } w_code_e;

  // 2 and 3 behave like pad_zero
  typedef enum logic [1:0] {
    pad_zero = 2'd0,
    pad_edge = 2'd1
  } pad_e;

endpackage

// ==== conv_mem_pkg.sv ====
package conv_mem_pkg;

  localparam int addr_w     = 32;
  localparam int max_len    = 64;
  localparam int len_w      = $clog2(max_len);  // length field, len = field + 1
  localparam int word_shift = 2;                // word index to byte address

  // word offsets inside each memory
  localparam int param_word  = 0;
  localparam int weight_word = 0;
  localparam int bias_base   = 0;
  localparam int in_base     = 0;
  localparam int out_base    = 0;

  // parameter word fields, low bit of each
  localparam int pos_w_lsb  = 24;
  localparam int neg_w1_lsb = 16;
  localparam int neg_w2_lsb = 8;
  localparam int pad_lsb    = 6;
  localparam int len_lsb    = 0;

  typedef enum logic [2:0] {
    st_idle,
    st_param,
    st_weight,
    st_bias,
    st_stream,
    st_drain,
    st_done
  } ctrl_state_e;

endpackage

// ==== conv_ctrl.sv ====
`timescale 1ns/100ps

module conv_ctrl
  import conv_pkg::*;
  import conv_mem_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic [data_w-1:0]   param_data,
  input  logic                rd_last,
  input  logic                wr_last,
  output logic                finish,
  output logic                param_en,
  output logic                w_en,
  output logic                b_en,
  output logic [ch_sel_w-1:0] b_sel,
  output logic                in_en,
  output logic                shift_en,
  output logic                first_smp,
  output logic                drain,
  output logic                rd_inc,
  output logic                clr,
  output logic                cfg_load,
  output logic                w_load,
  output logic                b_load
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  logic        last_rd;  // last sample is on its way back

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:   if (start) state_nxt = st_param;
      st_param:  state_nxt = st_weight;
      st_weight: state_nxt = st_bias;
      st_bias:   if (b_sel == ch_sel_w'(n_ch - 1)) state_nxt = st_stream;
      st_stream: if (rd_last) state_nxt = st_drain;
      st_drain:  if (wr_last) state_nxt = st_done;  // wr_last rises with the final write
      st_done:   state_nxt = st_idle;
      default:   state_nxt = st_idle;
    endcase
  end

  assign param_en = (state == st_param);
  assign w_en     = (state == st_weight);
  assign b_en     = (state == st_bias);
  assign in_en    = (state == st_stream);
  assign rd_inc   = in_en;
  assign clr      = (state == st_idle) && start;
  assign finish   = (state == st_done);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= st_idle;
      b_sel     <= '0;
      cfg_load  <= 1'b0;
      w_load    <= 1'b0;
      b_load    <= 1'b0;
      shift_en  <= 1'b0;
      first_smp <= 1'b0;
      last_rd   <= 1'b0;
      drain     <= 1'b0;
    end else begin
      state <= state_nxt;
      if (b_en) begin
        b_sel <= b_sel + 1'b1;  // wraps to 0 after the last bias
      end
      // read data comes back one cycle after the request
      cfg_load  <= param_en;
      w_load    <= w_en;
      b_load    <= b_en;
      shift_en  <= in_en;
      first_smp <= in_en && !shift_en;
      last_rd   <= in_en && rd_last;
      drain     <= last_rd;  // one pad shift after the last sample
    end
  end

  // input reads only in a stream that was entered from the bias loads
  a_in_en_stream: assert property (@(posedge clk) disable iff (!rst)
    in_en |-> (state == st_stream) && ($past(state) inside {st_bias, st_stream}));

  a_finish_pulse: assert property (@(posedge clk) disable iff (!rst)
    finish |=> !finish);

  // a length of 1 is not supported
  a_len_min: assert property (@(posedge clk) disable iff (!rst)
    cfg_load |-> param_data[len_lsb +: len_w] != '0);

endmodule

// ==== conv_pos_cnt.sv ====
`timescale 1ns/100ps

module conv_pos_cnt
  import conv_mem_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             clr,
  input  logic             rd_inc,
  input  logic             wr_inc,
  input  logic [len_w-1:0] len_field,
  output logic [len_w-1:0] rd_idx,
  output logic [len_w-1:0] wr_idx,
  output logic             rd_last,
  output logic             wr_last
);

  assign rd_last = (rd_idx == len_field);
  assign wr_last = (wr_idx == len_field);

  // both counters stop at the last index until the next clear
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rd_idx <= '0;
      wr_idx <= '0;
    end else if (clr) begin
      rd_idx <= '0;
      wr_idx <= '0;
    end else begin
      if (rd_inc && !rd_last) begin
        rd_idx <= rd_idx + 1'b1;
      end
      if (wr_inc && !wr_last) begin
        wr_idx <= wr_idx + 1'b1;
      end
    end
  end

  a_idx_range: assert property (@(posedge clk) disable iff (!rst)
    (rd_idx <= len_field) && (wr_idx <= len_field));

endmodule

// ==== conv_window.sv ====
`timescale 1ns/100ps

module conv_window
  import conv_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [data_w-1:0]          in_data,
  input  logic                       shift_en,
  input  logic                       first_smp,
  input  logic                       drain,
  input  pad_e                       padding,
  output logic signed [sample_w-1:0] win0,  // x[i-1]
  output logic signed [sample_w-1:0] win1,  // x[i]
  output logic signed [sample_w-1:0] win2,  // x[i+1]
  output logic                       win_valid
);

  logic signed [sample_w-1:0] smp;
  logic                       edge_pad;

  assign smp      = in_data[sample_w-1:0];  // one sample per word, low byte
  assign edge_pad = (padding == pad_edge);

  // every shift except the first one completes a window
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      win_valid <= 1'b0;
    end else begin
      win_valid <= (shift_en && !first_smp) || drain;
    end
  end

  always_ff @(posedge clk) begin
    if (shift_en && first_smp) begin
      win1 <= edge_pad ? smp : '0;  // left pad
      win2 <= smp;
    end else if (shift_en) begin
      win0 <= win1;
      win1 <= win2;
      win2 <= smp;
    end else if (drain) begin
      win0 <= win1;
      win1 <= win2;
      win2 <= edge_pad ? win2 : '0;  // right pad repeats the last sample
    end
  end

endmodule

// ==== conv_unit.sv ====
`timescale 1ns/100ps

module conv_unit
  import conv_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic signed [sample_w-1:0] win0,
  input  logic signed [sample_w-1:0] win1,
  input  logic signed [sample_w-1:0] win2,
  input  logic                       win_valid,
  input  logic [ch_code_w-1:0]       w_codes,
  input  logic [mag_w-1:0]           pos_w,
  input  logic [mag_w-1:0]           neg_w1,
  input  logic [mag_w-1:0]           neg_w2,
  input  logic [data_w-1:0]          bias,
  input  logic                       bias_load,
  input  logic                       code_load,
  output logic [sample_w-1:0]        res,
  output logic                       res_valid
);

  logic [ch_code_w-1:0]       codes_q;
  logic signed [acc_w-1:0]    bias_q;
  logic signed [acc_w-1:0]    pos_ext;
  logic signed [acc_w-1:0]    neg1_ext;
  logic signed [acc_w-1:0]    neg2_ext;
  logic signed [sample_w-1:0] smp [n_tap];
  logic signed [acc_w-1:0]    term [n_tap];
  logic signed [acc_w+1:0]    sum;  // two guard bits so bias extremes cannot wrap

  function automatic logic signed [acc_w-1:0] tap_term(
    input logic signed [sample_w-1:0] s,
    input w_code_e                    code
  );
    logic signed [acc_w-1:0] s_ext;
    s_ext = acc_w'(s);
    case (code)
      w_zero: tap_term = '0;
      w_pos:  tap_term = s_ext * pos_ext;
      w_neg1: tap_term = -(s_ext * neg1_ext);
      w_neg2: tap_term = -(s_ext * neg2_ext);
    endcase
  endfunction

  assign pos_ext  = acc_w'(pos_w);  // magnitudes are unsigned
  assign neg1_ext = acc_w'(neg_w1);
  assign neg2_ext = acc_w'(neg_w2);

  assign smp[0] = win0;
  assign smp[1] = win1;
  assign smp[2] = win2;

  always_comb begin
    for (int t = 0; t < n_tap; t++) begin
      term[t] = tap_term(smp[t], w_code_e'(codes_q[t*code_w +: code_w]));
    end
  end

  assign sum = term[0] + term[1] + term[2] + bias_q;

  always_ff @(posedge clk) begin
    if (code_load) codes_q <= w_codes;
    if (bias_load) bias_q <= bias;
    if (sum > sat_max) begin
      res <= sample_w'(sat_max);
    end else if (sum < sat_min) begin
      res <= sample_w'(sat_min);
    end else begin
      res <= sum[sample_w-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= win_valid;
    end
  end

  a_res_lat: assert property (@(posedge clk) disable iff (!rst)
    res_valid == $past(win_valid));

endmodule

// ==== conv_top.sv ====
`timescale 1ns/100ps

module conv_top
  import conv_pkg::*;
  import conv_mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  output logic              finish,

  output logic              param_en,
  output logic [addr_w-1:0] param_addr,
  input  logic [data_w-1:0] param_data,

  output logic              w_en,
  output logic [addr_w-1:0] w_addr,
  input  logic [data_w-1:0] w_data,

  output logic              b_en,
  output logic [addr_w-1:0] b_addr,
  input  logic [data_w-1:0] b_data,

  output logic              in_en,
  output logic [addr_w-1:0] in_addr,
  input  logic [data_w-1:0] in_data,

  output logic              out_en,
  output logic [addr_w-1:0] out_addr,
  output logic [be_w-1:0]   out_w_req,
  output logic [data_w-1:0] out_w_data
);

  logic [ch_sel_w-1:0]        b_sel;
  logic [ch_sel_w-1:0]        b_sel_q;  // bias index of the returning word
  logic                       shift_en;
  logic                       first_smp;
  logic                       drain;
  logic                       rd_inc;
  logic                       clr;
  logic                       cfg_load;
  logic                       w_load;
  logic                       b_load;
  logic [len_w-1:0]           rd_idx;
  logic [len_w-1:0]           wr_idx;
  logic                       rd_last;
  logic                       wr_last;
  logic [len_w-1:0]           len_q;
  pad_e                       pad_q;
  logic [mag_w-1:0]           pos_w_q;
  logic [mag_w-1:0]           neg_w1_q;
  logic [mag_w-1:0]           neg_w2_q;
  logic signed [sample_w-1:0] win0;
  logic signed [sample_w-1:0] win1;
  logic signed [sample_w-1:0] win2;
  logic                       win_valid;
  logic [sample_w-1:0]        res [n_ch];
  logic [n_ch-1:0]            res_vld;

  assign param_addr = addr_w'(param_word << word_shift);
  assign w_addr     = addr_w'(weight_word << word_shift);
  assign b_addr     = addr_w'((bias_base + int'(b_sel)) << word_shift);
  assign in_addr    = addr_w'((in_base + int'(rd_idx)) << word_shift);
  assign out_addr   = addr_w'((out_base + int'(wr_idx)) << word_shift);

  assign out_en    = res_vld[0];
  assign out_w_req = {be_w{out_en}};

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      len_q   <= '0;
      pad_q   <= pad_zero;
      b_sel_q <= '0;
    end else begin
      b_sel_q <= b_sel;
      if (cfg_load) begin
        len_q <= param_data[len_lsb +: len_w];
        pad_q <= pad_e'(param_data[pad_lsb +: $bits(pad_e)]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_load) begin
      pos_w_q  <= param_data[pos_w_lsb +: mag_w];
      neg_w1_q <= param_data[neg_w1_lsb +: mag_w];
      neg_w2_q <= param_data[neg_w2_lsb +: mag_w];
    end
  end

  conv_ctrl i_ctrl (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .param_data(param_data),
    .rd_last   (rd_last),
    .wr_last   (wr_last),
    .finish    (finish),
    .param_en  (param_en),
    .w_en      (w_en),
    .b_en      (b_en),
    .b_sel     (b_sel),
    .in_en     (in_en),
    .shift_en  (shift_en),
    .first_smp (first_smp),
    .drain     (drain),
    .rd_inc    (rd_inc),
    .clr       (clr),
    .cfg_load  (cfg_load),
    .w_load    (w_load),
    .b_load    (b_load)
  );

  conv_pos_cnt i_pos_cnt (
    .clk      (clk),
    .rst      (rst),
    .clr      (clr),
    .rd_inc   (rd_inc),
    .wr_inc   (res_vld[0]),
    .len_field(len_q),
    .rd_idx   (rd_idx),
    .wr_idx   (wr_idx),
    .rd_last  (rd_last),
    .wr_last  (wr_last)
  );

  conv_window i_window (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .shift_en (shift_en),
    .first_smp(first_smp),
    .drain    (drain),
    .padding  (pad_q),
    .win0     (win0),
    .win1     (win1),
    .win2     (win2),
    .win_valid(win_valid)
  );

  for (genvar c = 0; c < n_ch; c++) begin : g_ch
    conv_unit i_unit (
      .clk      (clk),
      .rst      (rst),
      .win0     (win0),
      .win1     (win1),
      .win2     (win2),
      .win_valid(win_valid),
      .w_codes  (w_data[c*ch_code_w +: ch_code_w]),
      .pos_w    (pos_w_q),
      .neg_w1   (neg_w1_q),
      .neg_w2   (neg_w2_q),
      .bias     (b_data),
      .bias_load(b_load && (b_sel_q == ch_sel_w'(c))),
      .code_load(w_load),
      .res      (res[c]),
      .res_valid(res_vld[c])
    );
    assign out_w_data[c*sample_w +: sample_w] = res[c];  // channel c in byte c
  end

endmodule

// ==== conv_checker.sv ====
`timescale 1ns/100ps

module conv_checker
  import conv_pkg::*;
  import conv_mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              finish,
  input  logic              param_en,
  input  logic              w_en,
  input  logic              b_en,
  input  logic              in_en,
  input  logic              out_en,
  input  logic [addr_w-1:0] out_addr,
  input  logic [be_w-1:0]   out_w_req,
  input  logic [data_w-1:0] out_w_data,
  output int                mismatches,
  output int                faults
);

  logic [data_w-1:0] exp_word [max_len];
  int                exp_len = 0;
  int                wr_cnt = 0;
  int                mism_cnt = 0;
  int                fault_cnt = 0;
  bit                busy = 1'b0;
  bit                started = 1'b0;
  bit                fin_due = 1'b0;  // final write seen, finish expected now

  assign mismatches = mism_cnt;
  assign faults     = fault_cnt;

  task automatic report_mismatch(input string name, input logic [data_w-1:0] exp_v,
                                 input logic [data_w-1:0] got_v);
    mism_cnt++;
    $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp_v, got_v);
  endtask

  task automatic report_fault(input string msg);
    fault_cnt++;
    $display("at %0t: %s", $time, msg);
  endtask

  // reference model straight from the memory contents of the testbench
  task automatic build_expected();
    logic [data_w-1:0]          prm;
    logic [data_w-1:0]          wgt;
    logic signed [sample_w-1:0] x [max_len+2];  // x[k] holds sample k-1
    longint                     acc;
    longint                     mag;
    int                         len;
    bit                         edge_pad;
    prm = conv_tb.param_mem[0];
    wgt = conv_tb.w_mem[0];
    len = int'(prm[5:0]) + 1;
    edge_pad = (prm[7:6] == 2'd1);
    for (int j = 0; j < len; j++) begin
      x[j+1] = conv_tb.in_mem[j][7:0];
    end
    x[0] = edge_pad ? x[1] : '0;
    x[len+1] = edge_pad ? x[len] : '0;
    for (int i = 0; i < len; i++) begin
      for (int c = 0; c < n_ch; c++) begin
        acc = longint'($signed(conv_tb.b_mem[c]));
        for (int t = 0; t < n_tap; t++) begin
          case (w_code_e'(wgt[6*c + 2*t +: 2]))
            w_pos:   mag = longint'(prm[31:24]);
            w_neg1:  mag = -longint'(prm[23:16]);
            w_neg2:  mag = -longint'(prm[15:8]);
            default: mag = 0;
          endcase
          acc = acc + mag * longint'(x[i+t]);
        end
        if (acc > 127) begin
          acc = 127;
        end else if (acc < -128) begin
          acc = -128;
        end
        exp_word[i][8*c +: 8] = acc[7:0];
      end
    end
    exp_len = len;
  endtask

  task automatic check_write();
    if (!busy || wr_cnt >= exp_len) begin
      report_fault($sformatf("unexpected write to address %0h with no write pending", out_addr));
    end else begin
      if (out_addr != addr_w'(wr_cnt * 4)) begin
        report_fault($sformatf("write went to address %0h instead of %0h",
                               out_addr, wr_cnt * 4));
      end
      if (out_w_req != 4'hf) begin
        report_mismatch("out_w_req", 32'hf, 32'(out_w_req));
      end
      for (int c = 0; c < n_ch; c++) begin
        if (out_w_data[8*c +: 8] != exp_word[wr_cnt][8*c +: 8]) begin
          report_mismatch($sformatf("out_w_data[%0d:%0d] of word %0d", 8*c + 7, 8*c, wr_cnt),
                          32'(exp_word[wr_cnt][8*c +: 8]), 32'(out_w_data[8*c +: 8]));
        end
      end
      wr_cnt++;
      if (wr_cnt == exp_len) begin
        fin_due = 1'b1;
      end
    end
  endtask

  always @(posedge clk) begin
    bit accept;
    accept = rst && start && !busy;  // start counts only while idle
    if (!rst) begin
      busy = 1'b0;
      wr_cnt = 0;
      fin_due = 1'b0;
    end
    if (!started && ({finish, param_en, w_en, b_en, in_en, out_en, out_w_req} != '0)) begin
      report_fault("a control output was active before the first start");
    end
    if (fin_due && !finish) begin
      report_fault("finish did not follow the final write");
    end
    fin_due = 1'b0;
    if (finish) begin
      if (!busy) begin
        report_fault("a second finish arrived with no run in progress");
      end else if (wr_cnt != exp_len) begin
        report_fault($sformatf("finish came after %0d of %0d writes", wr_cnt, exp_len));
      end
      busy = 1'b0;
    end
    if (out_en) begin
      check_write();
    end
    if (accept) begin
      build_expected();
      busy = 1'b1;
      wr_cnt = 0;
      started = 1'b1;
    end
  end

endmodule

// ==== conv_tb.sv ====
`timescale 1ns/100ps

module conv_tb
  import conv_pkg::*;
  import conv_mem_pkg::*;
();

  localparam int n_rand  = 30;
  localparam int n_runs  = n_rand + 4;  // random, two padding, saturation, busy start
  localparam int max_cyc = n_runs * (max_len + 40) + 100;

  logic              clk = 1'b0;
  logic              rst;
  logic              start;
  logic              finish;
  logic              param_en;
  logic [addr_w-1:0] param_addr;
  logic [data_w-1:0] param_data = '0;
  logic              w_en;
  logic [addr_w-1:0] w_addr;
  logic [data_w-1:0] w_data = '0;
  logic              b_en;
  logic [addr_w-1:0] b_addr;
  logic [data_w-1:0] b_data = '0;
  logic              in_en;
  logic [addr_w-1:0] in_addr;
  logic [data_w-1:0] in_data = '0;
  logic              out_en;
  logic [addr_w-1:0] out_addr;
  logic [be_w-1:0]   out_w_req;
  logic [data_w-1:0] out_w_data;

  logic [data_w-1:0] param_mem [4];
  logic [data_w-1:0] w_mem [4];
  logic [data_w-1:0] b_mem [n_ch];
  logic [data_w-1:0] in_mem [max_len];
  logic [data_w-1:0] out_mem [max_len];

  integer seed = 32'he04d_84a5;
  int     cycles = 0;
  int     tb_errors = 0;
  int     mismatches;
  int     faults;

  always #2 clk = ~clk;

  conv_top i_conv_top (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .finish    (finish),
    .param_en  (param_en),
    .param_addr(param_addr),
    .param_data(param_data),
    .w_en      (w_en),
    .w_addr    (w_addr),
    .w_data    (w_data),
    .b_en      (b_en),
    .b_addr    (b_addr),
    .b_data    (b_data),
    .in_en     (in_en),
    .in_addr   (in_addr),
    .in_data   (in_data),
    .out_en    (out_en),
    .out_addr  (out_addr),
    .out_w_req (out_w_req),
    .out_w_data(out_w_data)
  );

  conv_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .finish    (finish),
    .param_en  (param_en),
    .w_en      (w_en),
    .b_en      (b_en),
    .in_en     (in_en),
    .out_en    (out_en),
    .out_addr  (out_addr),
    .out_w_req (out_w_req),
    .out_w_data(out_w_data),
    .mismatches(mismatches),
    .faults    (faults)
  );

  // one-cycle synchronous memories
  always @(posedge clk) begin
    if (param_en) begin
      param_data <= #1 param_mem[param_addr[3:2]];
    end
    if (w_en) begin
      w_data <= #1 w_mem[w_addr[3:2]];
    end
    if (b_en) begin
      b_data <= #1 b_mem[b_addr[3:2]];
    end
    if (in_en) begin
      in_data <= #1 in_mem[in_addr[7:2]];
    end
    if (out_en) begin
      for (int b = 0; b < be_w; b++) begin
        if (out_w_req[b]) begin
          out_mem[out_addr[7:2]][8*b +: 8] <= out_w_data[8*b +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > max_cyc) begin
      $display("timeout after %0d cycles, the DUT never raised finish", cycles);
      $display("errors: %0d mismatches, %0d other", mismatches, faults + tb_errors + 1);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // mag_mask keeps some runs out of saturation
  task automatic fill_random(input int len, input logic [1:0] pad, input logic [7:0] mag_mask);
    logic [data_w-1:0] r;
    r = $random(seed);
    param_mem[0] = {r[31:24] & mag_mask, r[23:16] & mag_mask, r[15:8] & mag_mask,
                    pad, 6'(len - 1)};
    w_mem[0] = $random(seed);
    for (int c = 0; c < n_ch; c++) begin
      r = $random(seed);
      b_mem[c] = {{22{r[9]}}, r[9:0]};
    end
    for (int j = 0; j < max_len; j++) begin
      in_mem[j] = $random(seed);
    end
  endtask

  // called 1 ns after an edge, returns 1 ns after the edge that follows finish
  task automatic run_conv(input int poke_at);
    int cyc;
    start = 1'b1;
    idle_cycles(1);
    start = 1'b0;
    cyc = 0;
    while (!finish) begin
      cyc++;
      start = (cyc == poke_at);  // stray start while busy
      idle_cycles(1);
    end
    start = 1'b0;
    idle_cycles(1);
  endtask

  initial begin
    int                len;
    logic [data_w-1:0] first_zero;
    logic [data_w-1:0] last_zero;
    rst = 1'b0;
    start = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b1;
    idle_cycles(2);

    for (int r = 0; r < n_rand; r++) begin
      len = 2 + int'($unsigned($random(seed)) % 63);
      fill_random(len, 2'($random(seed)), r[0] ? 8'h03 : 8'hff);
      run_conv(0);
      idle_cycles((r % 3 == 0) ? 2 : 0);  // mostly back to back
    end

    // large edge samples, all taps w_pos with pos_w 1 and no bias
    fill_random(16, 2'd0, 8'hff);
    param_mem[0][31:8] = 24'h01_02_03;
    w_mem[0] = 32'h0055_5555;
    for (int c = 0; c < n_ch; c++) begin
      b_mem[c] = '0;
    end
    in_mem[0] = 32'h0000_0064;
    in_mem[1] = '0;
    in_mem[14] = '0;
    in_mem[15] = 32'h0000_009c;
    run_conv(0);
    first_zero = out_mem[0];
    last_zero = out_mem[15];
    param_mem[0][7:6] = 2'd1;
    run_conv(0);
    if (out_mem[0] == first_zero || out_mem[15] == last_zero) begin
      tb_errors++;
      $display("edge padding left the first or last output word unchanged");
    end

    fill_random(48, 2'($random(seed)), 8'hff);
    param_mem[0][31:8] = 24'hff_ff_ff;
    b_mem[0] = 32'h7fff_ff00;
    b_mem[1] = 32'h8000_0100;
    b_mem[2] = 32'h7fff_ffff;
    b_mem[3] = 32'h8000_0000;
    run_conv(0);

    fill_random(40, 2'd1, 8'h0f);
    run_conv(20);

    idle_cycles(4);
    $display("errors: %0d mismatches, %0d other", mismatches, faults + tb_errors);
    if (mismatches + faults + tb_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
conv_pkg.sv
conv_mem_pkg.sv
conv_ctrl.sv
conv_pos_cnt.sv
conv_window.sv
conv_unit.sv
conv_top.sv
conv_checker.sv
conv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module conv_tb -f filelist.f -o conv_sim
./obj_dir/conv_sim | tee sim.log

if grep -qx "All tests passed" sim.log; then
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
